//--- include/sample_buffer_defs.svh
// sample buffer constants
`ifndef SAMPLE_BUFFER_DEFS_SVH
`define SAMPLE_BUFFER_DEFS_SVH

// one bank per channel
`define SB_CHANNELS 4

// words per bank
`define SB_BUFFER_DEPTH 16

`define SB_DATA_WIDTH 16

// cycles from read request to data
`define SB_READ_LATENCY 2

`endif

//--- design/sample_buffer_pkg.sv
// sample buffer types
`default_nettype none

`include "sample_buffer_defs.svh"

package sample_buffer_pkg;

  typedef logic [`SB_DATA_WIDTH-1:0] sample_t;

  // bank number, also used as a channel number
  typedef logic [$clog2(`SB_CHANNELS)-1:0] bank_idx_t;

  typedef logic [$clog2(`SB_BUFFER_DEPTH)-1:0] bank_addr_t;

  // counts up to a full bank, so one bit wider than an address
  typedef logic [$clog2(`SB_BUFFER_DEPTH+1)-1:0] depth_t;

  // 2^m active channels
  typedef logic [$clog2($clog2(`SB_CHANNELS)+1)-1:0] banking_mode_t;

endpackage

`default_nettype wire

//--- design/bank_ports_if.sv
// bank write and read ports
`timescale 1ns/100ps
`default_nettype none

interface bank_write_if;
  import sample_buffer_pkg::*;

  logic wr_en;
  bank_idx_t wr_bank;
  bank_addr_t wr_addr;
  sample_t wr_data;

  modport producer (output wr_en, wr_bank, wr_addr, wr_data);
  modport memory (input wr_en, wr_bank, wr_addr, wr_data);

endinterface

// rd_data follows rd_en by the memory read latency
interface bank_read_if;
  import sample_buffer_pkg::*;

  logic rd_en;
  bank_idx_t rd_bank;
  bank_addr_t rd_addr;
  sample_t rd_data;

  modport consumer (output rd_en, rd_bank, rd_addr, input rd_data);
  modport memory (input rd_en, rd_bank, rd_addr, output rd_data);

endinterface

`default_nettype wire

//--- design/capture_banker.sv
// capture channel to bank mapping
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module capture_banker (
  input  logic capture_clk,
  input  logic readout_reset,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic capture_sw_reset,
  input  sample_buffer_pkg::sample_t [`SB_CHANNELS-1:0] capture_data,
  input  logic [`SB_CHANNELS-1:0] capture_valid,
  input  sample_buffer_pkg::banking_mode_t capture_banking_mode,
  output logic capture_full,
  output sample_buffer_pkg::depth_t [`SB_CHANNELS-1:0] write_depth,
  bank_write_if.producer wr
);
  import sample_buffer_pkg::*;

  localparam int unsigned CH = `SB_CHANNELS;

  // one bit wider than a bank index to see a step past the last bank
  typedef logic [$clog2(CH):0] bank_step_t;

  logic running;
  banking_mode_t mode_q;
  bank_step_t step;
  logic [CH-1:0] active;
  logic [CH-1:0] in_valid;
  logic [CH-1:0] src_valid;
  logic [CH-1:0] hold_valid;
  sample_t hold_data [CH];
  bank_idx_t cur_bank [CH];
  bank_addr_t next_addr [CH];
  bank_idx_t rr_ptr;
  bank_idx_t grant;
  logic grant_any;
  logic [CH-1:0] granted;
  bank_step_t adv_bank;
  logic bank_done;
  logic channel_done;
  logic capture_end;

  assign step = bank_step_t'(1) << mode_q;

  always_comb begin
    for (int c = 0; c < CH; c++) begin
      active[c] = (bank_step_t'(c) < step);
      in_valid[c] = running && active[c] && capture_valid[c];
      src_valid[c] = hold_valid[c] || in_valid[c];
    end
  end

  // rotating priority starting at rr_ptr
  always_comb begin
    bank_idx_t idx;
    grant = rr_ptr;
    grant_any = 1'b0;
    for (int i = 0; i < CH; i++) begin
      idx = rr_ptr + bank_idx_t'(i);
      if (!grant_any && src_valid[idx]) begin
        grant = idx;
        grant_any = 1'b1;
      end
    end
    for (int c = 0; c < CH; c++) begin
      granted[c] = grant_any && (grant == bank_idx_t'(c));
    end
  end

  // a held sample is older than the one on the input
  assign wr.wr_en = grant_any;
  assign wr.wr_bank = cur_bank[grant];
  assign wr.wr_addr = next_addr[grant];
  assign wr.wr_data = hold_valid[grant] ? hold_data[grant] : capture_data[grant];

  assign bank_done = (next_addr[grant] == bank_addr_t'(`SB_BUFFER_DEPTH - 1));
  assign adv_bank = bank_step_t'(cur_bank[grant]) + step;
  assign channel_done = grant_any && bank_done && (adv_bank >= bank_step_t'(CH));
  assign capture_end = capture_stop || channel_done;

  always_ff @(posedge capture_clk) begin
    if (readout_reset || capture_sw_reset) begin
      running <= 1'b0;
      capture_full <= 1'b0;
      write_depth <= '0;
      hold_valid <= '0;
      rr_ptr <= '0;
      mode_q <= '0;
      for (int c = 0; c < CH; c++) begin
        cur_bank[c] <= bank_idx_t'(c);
        next_addr[c] <= '0;
      end
    end else if (capture_start) begin
      running <= 1'b1;
      capture_full <= 1'b0;
      write_depth <= '0;
      hold_valid <= '0;
      rr_ptr <= '0;
      mode_q <= capture_banking_mode;
      for (int c = 0; c < CH; c++) begin
        cur_bank[c] <= bank_idx_t'(c);
        next_addr[c] <= '0;
      end
    end else begin
      if (grant_any) begin
        write_depth[cur_bank[grant]] <= write_depth[cur_bank[grant]] + 1'b1;
        rr_ptr <= grant + 1'b1;
        if (bank_done) begin
          // channel moves on by 2^m banks
          cur_bank[grant] <= bank_idx_t'(adv_bank);
          next_addr[grant] <= '0;
        end else begin
          next_addr[grant] <= next_addr[grant] + 1'b1;
        end
      end
      if (channel_done) begin
        capture_full <= 1'b1;
      end
      if (capture_end) begin
        running <= 1'b0;
        hold_valid <= '0;
      end else begin
        hold_valid <= (hold_valid & in_valid & granted) | ((hold_valid | in_valid) & ~granted);
      end
    end
  end

  // occupied and not written this cycle means the new sample is dropped
  always_ff @(posedge capture_clk) begin
    for (int c = 0; c < CH; c++) begin
      if (in_valid[c] && (!hold_valid[c] || granted[c])) begin
        hold_data[c] <= capture_data[c];
      end
    end
  end

endmodule

`default_nettype wire

//--- design/bank_memory.sv
// banked sample memory
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module bank_memory (
  input logic capture_clk,
  bank_write_if.memory wr,
  bank_read_if.memory rd
);
  import sample_buffer_pkg::*;

  localparam int unsigned LAT = `SB_READ_LATENCY;

  sample_t bank_word [`SB_CHANNELS];
  sample_t rd_pipe [LAT];

  for (genvar b = 0; b < `SB_CHANNELS; b++) begin : g_bank
    sample_t words [`SB_BUFFER_DEPTH];

    always_ff @(posedge capture_clk) begin
      if (wr.wr_en && (wr.wr_bank == bank_idx_t'(b))) begin
        words[wr.wr_addr] <= wr.wr_data;
      end
    end

    // every bank looks up the same address, the pipe picks one
    assign bank_word[b] = words[rd.rd_addr];
  end

  // first stage holds the selected word, later stages only delay it
  always_ff @(posedge capture_clk) begin
    if (rd.rd_en) begin
      rd_pipe[0] <= bank_word[rd.rd_bank];
    end
    for (int s = 1; s < LAT; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rd.rd_data = rd_pipe[LAT-1];

endmodule

`default_nettype wire

//--- design/readout_sequencer.sv
// readout sequencer and skid queue
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module readout_sequencer (
  input  logic capture_clk,
  input  logic readout_reset,
  input  logic readout_start,
  input  logic readout_sw_reset,
  input  logic readout_ready,
  output sample_buffer_pkg::sample_t readout_data,
  output logic readout_valid,
  output logic readout_last,
  bank_read_if.consumer rd
);
  import sample_buffer_pkg::*;

  localparam int unsigned LAT = `SB_READ_LATENCY;
  localparam int unsigned QDEPTH = LAT + 1;

  typedef logic [$clog2(QDEPTH)-1:0] qptr_t;
  typedef logic [$clog2(QDEPTH+1)-1:0] qcount_t;

  logic running;
  logic issue_done;
  bank_idx_t issue_bank;
  bank_addr_t issue_addr;
  logic issue;
  logic issue_last;
  qcount_t outstanding;
  logic [LAT-1:0] vld_sr;
  logic [LAT-1:0] last_sr;
  sample_t q_data [QDEPTH];
  logic [QDEPTH-1:0] q_last;
  qptr_t q_wr_ptr;
  qptr_t q_rd_ptr;
  qcount_t q_count;
  logic push;
  logic pop;

  function automatic qptr_t next_ptr(input qptr_t ptr);
    return (ptr == qptr_t'(QDEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign issue_last = &{issue_bank, issue_addr};

  // outstanding counts queued words plus reads in flight
  assign issue = running && !issue_done && (outstanding < qcount_t'(QDEPTH));

  assign rd.rd_en = issue;
  assign rd.rd_bank = issue_bank;
  assign rd.rd_addr = issue_addr;

  assign push = vld_sr[LAT-1];
  assign readout_valid = (q_count != '0);
  assign readout_data = q_data[q_rd_ptr];
  assign readout_last = readout_valid && q_last[q_rd_ptr];
  assign pop = readout_valid && readout_ready;

  // bank 0 first, addresses in order
  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      running <= 1'b0;
      issue_done <= 1'b0;
      issue_bank <= '0;
      issue_addr <= '0;
    end else if (!running) begin
      if (readout_start) begin
        running <= 1'b1;
        issue_done <= 1'b0;
        issue_bank <= '0;
        issue_addr <= '0;
      end
    end else begin
      if (issue) begin
        if (issue_last) begin
          issue_done <= 1'b1;
        end else begin
          {issue_bank, issue_addr} <= {issue_bank, issue_addr} + 1'b1;
        end
      end
      if (pop && readout_last) begin
        running <= 1'b0;
      end
    end
  end

  always_ff @(posedge capture_clk) begin
    if (readout_reset || readout_sw_reset) begin
      vld_sr <= '0;
      outstanding <= '0;
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
      q_count <= '0;
    end else begin
      vld_sr[0] <= issue;
      for (int s = 1; s < LAT; s++) begin
        vld_sr[s] <= vld_sr[s-1];
      end
      outstanding <= outstanding + qcount_t'(issue) - qcount_t'(pop);
      if (push) begin
        q_wr_ptr <= next_ptr(q_wr_ptr);
      end
      if (pop) begin
        q_rd_ptr <= next_ptr(q_rd_ptr);
      end
      q_count <= q_count + qcount_t'(push) - qcount_t'(pop);
    end
  end

  // last tag travels beside the read
  always_ff @(posedge capture_clk) begin
    last_sr[0] <= issue_last;
    for (int s = 1; s < LAT; s++) begin
      last_sr[s] <= last_sr[s-1];
    end
    if (push) begin
      q_data[q_wr_ptr] <= rd.rd_data;
      q_last[q_wr_ptr] <= last_sr[LAT-1];
    end
  end

endmodule

`default_nettype wire

//--- design/sample_buffer.sv
// banked sample buffer top
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module sample_buffer (
  input  logic capture_clk,
  input  logic readout_reset,
  input  sample_buffer_pkg::sample_t [`SB_CHANNELS-1:0] capture_data,
  input  logic [`SB_CHANNELS-1:0] capture_valid,
  input  sample_buffer_pkg::banking_mode_t capture_banking_mode,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic capture_sw_reset,
  output logic capture_full,
  output sample_buffer_pkg::depth_t [`SB_CHANNELS-1:0] capture_write_depth,
  input  logic readout_start,
  input  logic readout_sw_reset,
  output sample_buffer_pkg::sample_t readout_data,
  output logic readout_valid,
  input  logic readout_ready,
  output logic readout_last
);

  bank_write_if wr_bus ();
  bank_read_if rd_bus ();

  capture_banker banker_i (
    .capture_clk,
    .readout_reset,
    .capture_start,
    .capture_stop,
    .capture_sw_reset,
    .capture_data,
    .capture_valid,
    .capture_banking_mode,
    .capture_full,
    .write_depth (capture_write_depth),
    .wr (wr_bus.producer)
  );

  bank_memory memory_i (
    .capture_clk,
    .wr (wr_bus.memory),
    .rd (rd_bus.memory)
  );

  readout_sequencer sequencer_i (
    .capture_clk,
    .readout_reset,
    .readout_start,
    .readout_sw_reset,
    .readout_ready,
    .readout_data,
    .readout_valid,
    .readout_last,
    .rd (rd_bus.consumer)
  );

endmodule

`default_nettype wire

//--- test/sample_buffer_assert.sv
// sample buffer protocol assertions
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module sample_buffer_assert (
  input logic capture_clk,
  input logic readout_reset,
  input logic readout_sw_reset,
  input logic capture_full,
  input sample_buffer_pkg::depth_t [`SB_CHANNELS-1:0] capture_write_depth,
  input sample_buffer_pkg::sample_t readout_data,
  input logic readout_valid,
  input logic readout_ready,
  input logic readout_last
);
  import sample_buffer_pkg::*;

  // a stalled word stays put until it is taken
  stall_hold: assert property (@(posedge capture_clk)
    readout_valid && !readout_ready && !readout_reset && !readout_sw_reset
    |=> readout_valid && $stable(readout_data) && $stable(readout_last))
    else $error("readout word changed while stalled");

  // nothing is left in the stream once the final word is taken
  last_ends_pass: assert property (@(posedge capture_clk)
    readout_valid && readout_ready && readout_last |=> !readout_valid)
    else $error("readout_valid high after the last word was taken");

  for (genvar b = 0; b < `SB_CHANNELS; b++) begin : g_depth
    depth_bound: assert property (@(posedge capture_clk)
      capture_write_depth[b] <= depth_t'(`SB_BUFFER_DEPTH))
      else $error("write depth of bank %0d above bank size", b);
  end

  reset_state: assert property (@(posedge capture_clk)
    readout_reset |=> !capture_full && !readout_valid && !readout_last)
    else $error("capture_full or readout flags high after reset");

endmodule

`default_nettype wire

//--- test/sample_buffer_checker.sv
// sample buffer reference model and checks
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module sample_buffer_checker (
  input  logic capture_clk,
  input  logic readout_reset,
  input  sample_buffer_pkg::sample_t [`SB_CHANNELS-1:0] capture_data,
  input  logic [`SB_CHANNELS-1:0] capture_valid,
  input  sample_buffer_pkg::banking_mode_t capture_banking_mode,
  input  logic capture_start,
  input  logic capture_stop,
  input  logic capture_sw_reset,
  input  logic capture_full,
  input  sample_buffer_pkg::depth_t [`SB_CHANNELS-1:0] capture_write_depth,
  input  logic readout_start,
  input  logic readout_sw_reset,
  input  sample_buffer_pkg::sample_t readout_data,
  input  logic readout_valid,
  input  logic readout_ready,
  input  logic readout_last,
  input  logic test_end,
  input  int test_num,
  input  logic check_stream,
  output int pass_count,
  output int fail_count
);
  import sample_buffer_pkg::*;

  localparam int NCH = `SB_CHANNELS;
  localparam int DEPTH = `SB_BUFFER_DEPTH;
  localparam int WORDS = NCH * DEPTH;

  sample_t model_mem [NCH][DEPTH];
  int model_depth [NCH];
  int chan_count [NCH];
  int step;
  logic model_run;
  logic model_full;
  int word_idx;
  int errors;
  bit after_cap_reset;

  task automatic mismatch(input string name, input int expected, input int actual);
    $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, expected, actual);
    errors++;
  endtask

  task automatic fault(input string what);
    $display("ERROR at %0t: %s", $time, what);
    errors++;
  endtask

  task automatic clear_model();
    for (int b = 0; b < NCH; b++) begin
      model_depth[b] = 0;
      chan_count[b] = 0;
    end
    model_full = 1'b0;
  endtask

  // k-th sample of channel c lands in bank c + (k / DEPTH) * 2^m
  task automatic record_sample(input int c, input sample_t data);
    int k;
    int bank;
    k = chan_count[c];
    bank = c + (k / DEPTH) * step;
    model_mem[bank][k % DEPTH] = data;
    model_depth[bank]++;
    chan_count[c] = k + 1;
    if ((k + 1) % DEPTH == 0 && bank + step >= NCH) begin
      model_full = 1'b1;
      model_run = 1'b0;
    end
  endtask

  task automatic compare_capture();
    for (int b = 0; b < NCH; b++) begin
      if (int'(capture_write_depth[b]) != model_depth[b]) begin
        mismatch($sformatf("capture_write_depth[%0d]", b), model_depth[b],
                 int'(capture_write_depth[b]));
      end
    end
    if (capture_full !== model_full) begin
      mismatch("capture_full", int'(model_full), int'(capture_full));
    end
  endtask

  task automatic report_test();
    compare_capture();
    if (readout_valid !== 1'b0) begin
      fault("readout_valid still high when the test ended");
    end
    if (check_stream && word_idx != WORDS) begin
      fault($sformatf("readout pass delivered %0d words instead of %0d", word_idx, WORDS));
    end
    if (errors == 0) begin
      $display("test %0d passed", test_num);
      pass_count++;
    end else begin
      $display("test %0d failed with %0d errors", test_num, errors);
      fail_count++;
    end
    errors = 0;
  endtask

  always @(posedge capture_clk) begin
    int bank;
    int addr;
    if (readout_valid && readout_ready && !readout_reset && !readout_sw_reset) begin
      if (word_idx >= WORDS) begin
        fault("readout delivered a word after the end of the pass");
      end else begin
        bank = word_idx / DEPTH;
        addr = word_idx % DEPTH;
        // only written addresses hold known samples
        if (addr < model_depth[bank] && readout_data !== model_mem[bank][addr]) begin
          mismatch($sformatf("readout_data (bank %0d, addr %0d)", bank, addr),
                   int'(model_mem[bank][addr]), int'(readout_data));
        end
        if (readout_last !== (word_idx == WORDS - 1)) begin
          mismatch("readout_last", int'(word_idx == WORDS - 1), int'(readout_last));
        end
      end
      word_idx++;
    end
    if (test_end) begin
      report_test();
    end
    // an aborted capture leaves every depth at zero
    if (after_cap_reset) begin
      compare_capture();
    end
    after_cap_reset = capture_sw_reset;
    if (readout_reset || capture_sw_reset) begin
      clear_model();
      model_run = 1'b0;
    end else if (capture_start) begin
      clear_model();
      model_run = 1'b1;
      step = 1 << capture_banking_mode;
    end else if (model_run) begin
      for (int c = 0; c < NCH; c++) begin
        if (model_run && capture_valid[c] && c < step) begin
          record_sample(c, capture_data[c]);
        end
      end
      if (capture_stop) begin
        model_run = 1'b0;
      end
    end
    if (readout_reset || readout_start || readout_sw_reset) begin
      word_idx = 0;
    end
    if (readout_reset) begin
      errors = 0;
      pass_count = 0;
      fail_count = 0;
    end
  end

endmodule

`default_nettype wire

//--- test/sample_buffer_tb.sv
// sample buffer testbench
`timescale 1ns/100ps
`default_nettype none

`include "sample_buffer_defs.svh"

module sample_buffer_tb;
  import sample_buffer_pkg::*;

  localparam int NCH = `SB_CHANNELS;
  localparam int NUM_ROWS = 8;
  localparam int FILL_LIMIT = 200;
  localparam int READ_LIMIT = 2000;

  // samples of zero means fill until capture_full
  typedef struct packed {
    banking_mode_t mode;
    logic [7:0] samples;
    logic cap_abort;
    logic rd_abort;
    logic [7:0] ready_pct;
  } scenario_t;

  scenario_t scenarios [NUM_ROWS] = '{
    '{2'd0, 8'd5, 1'b0, 1'b0, 8'd100},
    '{2'd1, 8'd20, 1'b0, 1'b0, 8'd70},
    '{2'd2, 8'd30, 1'b0, 1'b0, 8'd50},
    '{2'd0, 8'd0, 1'b0, 1'b0, 8'd60},
    '{2'd1, 8'd0, 1'b0, 1'b0, 8'd40},
    '{2'd2, 8'd0, 1'b0, 1'b0, 8'd80},
    '{2'd1, 8'd25, 1'b1, 1'b0, 8'd90},
    '{2'd2, 8'd40, 1'b0, 1'b1, 8'd50}
  };

  logic capture_clk = 1'b0;
  logic readout_reset;
  sample_t [NCH-1:0] capture_data;
  logic [NCH-1:0] capture_valid;
  banking_mode_t capture_banking_mode;
  logic capture_start;
  logic capture_stop;
  logic capture_sw_reset;
  logic capture_full;
  depth_t [NCH-1:0] capture_write_depth;
  logic readout_start;
  logic readout_sw_reset;
  sample_t readout_data;
  logic readout_valid;
  logic readout_ready;
  logic readout_last;
  logic test_end;
  int test_num;
  logic check_stream;
  int pass_count;
  int fail_count;
  int seed = 13376;
  bit timed_out;

  sample_buffer uut (.*);

  sample_buffer_checker checker_i (.*);

  bind sample_buffer sample_buffer_assert assert_i (.*);

  always #50 capture_clk = ~capture_clk;

  task automatic start_capture(input banking_mode_t mode);
    @(posedge capture_clk);
    capture_banking_mode <= mode;
    capture_start <= 1'b1;
    @(posedge capture_clk);
    capture_start <= 1'b0;
  endtask

  // one sample per cycle on a random active channel
  task automatic drive_sample(input banking_mode_t mode);
    int ch;
    ch = $unsigned($random(seed)) % (1 << mode);
    @(posedge capture_clk);
    capture_valid <= NCH'(1) << ch;
    capture_data[ch] <= sample_t'($random(seed));
  endtask

  task automatic end_samples();
    @(posedge capture_clk);
    capture_valid <= '0;
  endtask

  task automatic pulse_capture_control(input bit abort);
    @(posedge capture_clk);
    capture_valid <= '0;
    if (abort) begin
      capture_sw_reset <= 1'b1;
    end else begin
      capture_stop <= 1'b1;
    end
    @(posedge capture_clk);
    capture_sw_reset <= 1'b0;
    capture_stop <= 1'b0;
  endtask

  task automatic fill_until_full(input banking_mode_t mode);
    int n;
    n = 0;
    do begin
      drive_sample(mode);
      @(negedge capture_clk);
      n++;
      if (n > FILL_LIMIT) begin
        $display("ERROR at %0t: capture_full did not rise after %0d samples", $time, n);
        timed_out = 1'b1;
      end
    end while (!capture_full && !timed_out);
    // late samples must leave every depth alone
    repeat (3) drive_sample(mode);
    end_samples();
  endtask

  task automatic start_readout();
    @(posedge capture_clk);
    readout_start <= 1'b1;
    @(posedge capture_clk);
    readout_start <= 1'b0;
  endtask

  task automatic abort_readout(input int pct);
    repeat (20) begin
      readout_ready <= ($unsigned($random(seed)) % 100) < pct;
      @(posedge capture_clk);
    end
    readout_ready <= 1'b0;
    readout_sw_reset <= 1'b1;
    @(posedge capture_clk);
    readout_sw_reset <= 1'b0;
  endtask

  // runs until the word tagged last has been accepted
  task automatic read_pass(input int pct);
    int n;
    bit done;
    n = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      readout_ready <= ($unsigned($random(seed)) % 100) < pct;
      @(negedge capture_clk);
      done = readout_valid && readout_ready && readout_last;
      n++;
      if (n > READ_LIMIT) begin
        $display("ERROR at %0t: readout pass not finished after %0d cycles", $time, n);
        timed_out = 1'b1;
      end
      @(posedge capture_clk);
    end
    readout_ready <= 1'b0;
  endtask

  task automatic finish_test(input int num, input bit stream);
    repeat (2) @(posedge capture_clk);
    test_num <= num;
    check_stream <= stream;
    test_end <= 1'b1;
    @(posedge capture_clk);
    test_end <= 1'b0;
  endtask

  task automatic run_row(input int r);
    scenario_t s;
    s = scenarios[r];
    start_capture(s.mode);
    if (s.cap_abort) begin
      repeat (s.samples / 2) drive_sample(s.mode);
      pulse_capture_control(1'b1);
      start_capture(s.mode);
    end
    if (s.samples == 0) begin
      fill_until_full(s.mode);
    end else begin
      repeat (s.samples) drive_sample(s.mode);
      pulse_capture_control(1'b0);
    end
    if (s.rd_abort) begin
      start_readout();
      abort_readout(int'(s.ready_pct));
    end
    start_readout();
    read_pass(int'(s.ready_pct));
    finish_test(r + 1, 1'b1);
  endtask

  initial begin
    readout_reset = 1'b1;
    capture_data = '0;
    capture_valid = '0;
    capture_banking_mode = '0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    capture_sw_reset = 1'b0;
    readout_start = 1'b0;
    readout_sw_reset = 1'b0;
    readout_ready = 1'b0;
    test_end = 1'b0;
    test_num = 0;
    check_stream = 1'b0;
    timed_out = 1'b0;
    repeat (8) @(posedge capture_clk);
    readout_reset <= 1'b0;
    // state straight after reset
    finish_test(0, 1'b0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (!timed_out) begin
        run_row(r);
      end
    end
    repeat (4) @(posedge capture_clk);
    $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (!timed_out && fail_count == 0 && pass_count == NUM_ROWS + 1) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
design/sample_buffer_pkg.sv
design/bank_ports_if.sv
design/capture_banker.sv
design/bank_memory.sv
design/readout_sequencer.sv
design/sample_buffer.sv
test/sample_buffer_assert.sv
test/sample_buffer_checker.sv
test/sample_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sample buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert --top-module sample_buffer_tb -f flist.f -o sim_tb \
  || { echo "build failed"; exit 1; }
# a simulation stopped by an assertion also counts as a failure
./obj_dir/sim_tb > "$LOG" 2>&1 || echo 'Test failures found' >> "$LOG"
cat "$LOG"
grep -q 'Test failures found' "$LOG" && { echo "FAIL"; exit 1; }
grep -q 'All tests passed!' "$LOG" || { echo "FAIL"; exit 1; }
echo "PASS"
